// File: hw/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data memory geometry
// depth in 32-bit words as a power of two
`define MEM_WORDS 256

// cycles from request accept to response valid
// must be at least 1
`define MEM_LATENCY 2

`endif

// File: hw/core_types_pkg.sv
package core_types_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;

	typedef enum logic [2:0] {
		LD_NONE,
		LD_LB,
		LD_LH,
		LD_LW,
		LD_LBU,
		LD_LHU
	} load_op_e;

	typedef enum logic [1:0] {
		ST_NONE,
		ST_SB,
		ST_SH,
		ST_SW
	} store_op_e;

	// what execute hands to the memory stage
	typedef struct packed {
		word_t pc;
		word_t branch_target;
		word_t addr; // byte address
		word_t result;
		word_t store_data;
		reg_idx_t rd;
		load_op_e load_op;
		store_op_e store_op;
		logic is_branch;
		logic ecall;
		logic mret;
	} exu_req_t;

	typedef struct packed {
		word_t pc;
		word_t branch_target;
		word_t wdata;
		reg_idx_t rd;
		logic rd_we;
		logic is_branch;
		logic ecall;
		logic mret;
	} commit_t;

endpackage

// File: hw/mem_bus_pkg.sv
package mem_bus_pkg;
	import core_types_pkg::*;

	typedef logic [3:0] byte_en_t;
	typedef logic [29:0] word_addr_t; // byte address bits 31:2

	typedef struct packed {
		word_addr_t addr;
		logic we;
		byte_en_t be; // only looked at for writes
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		word_t rdata;
	} mem_rsp_t;

endpackage

// File: hw/lane_align.sv
`timescale 1ns/1ps

module lane_align import core_types_pkg::*, mem_bus_pkg::*; (
	input logic [1:0] addr_low,
	input load_op_e load_op,
	input store_op_e store_op,
	input word_t store_data,
	input word_t rdata,
	output word_t wdata,
	output byte_en_t be,
	output word_t load_value
);

	logic [7:0] rd_byte;
	logic [15:0] rd_half;

	// store data copied to every lane and be picks the real ones
	always_comb begin
		case (store_op)
			ST_SB: begin
				wdata = {4{store_data[7:0]}};
				be = byte_en_t'(4'b0001 << addr_low);
			end
			ST_SH: begin
				wdata = {2{store_data[15:0]}};
				be = addr_low[1] ? 4'b1100 : 4'b0011;
			end
			ST_SW: begin
				wdata = store_data;
				be = 4'b1111;
			end
			default: begin
				wdata = store_data;
				be = 4'b0000;
			end
		endcase
	end

	// load side
	assign rd_byte = rdata[8 * addr_low +: 8];
	assign rd_half = addr_low[1] ? rdata[31:16] : rdata[15:0];

	always_comb begin
		case (load_op)
			LD_LB: load_value = {{24{rd_byte[7]}}, rd_byte};
			LD_LBU: load_value = {24'b0, rd_byte};
			LD_LH: load_value = {{16{rd_half[15]}}, rd_half};
			LD_LHU: load_value = {16'b0, rd_half};
			default: load_value = rdata; // LW
		endcase
	end

endmodule

// File: hw/lsu.sv
`timescale 1ns/1ps

module lsu import core_types_pkg::*, mem_bus_pkg::*; (
	input logic clk,
	input logic rst,

	input logic exu_valid,
	output logic exu_ready,
	input exu_req_t exu_req,

	output logic mem_req_valid,
	input logic mem_req_ready,
	output mem_req_t mem_req,

	input logic mem_rsp_valid,
	output logic mem_rsp_ready,
	input mem_rsp_t mem_rsp,

	output logic lsu_valid,
	input logic wbu_ready,
	output commit_t lsu_commit
);

	typedef enum logic [2:0] {
		IDLE,
		WAIT_REQ_READ,
		WAIT_REQ_WRITE,
		WAIT_RSP_READ,
		WAIT_RSP_WRITE,
		WAIT_WBU_READY
	} lsu_state_e;

	lsu_state_e state;
	lsu_state_e next_state;

	exu_req_t req_q; // held for the whole access
	word_t load_q;
	word_t st_wdata;
	byte_en_t st_be;
	word_t load_value;

	assign exu_ready = (state == IDLE);
	assign mem_req_valid = (state == WAIT_REQ_READ) || (state == WAIT_REQ_WRITE);
	assign mem_rsp_ready = (state == WAIT_RSP_READ) || (state == WAIT_RSP_WRITE);
	assign lsu_valid = (state == WAIT_WBU_READY);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: if (exu_valid) begin
				if (exu_req.load_op != LD_NONE) next_state = WAIT_REQ_READ;
				else if (exu_req.store_op != ST_NONE) next_state = WAIT_REQ_WRITE;
				else next_state = WAIT_WBU_READY;
			end
			WAIT_REQ_READ: if (mem_req_ready) next_state = WAIT_RSP_READ;
			WAIT_REQ_WRITE: if (mem_req_ready) next_state = WAIT_RSP_WRITE;
			WAIT_RSP_READ: if (mem_rsp_valid) next_state = WAIT_WBU_READY;
			WAIT_RSP_WRITE: if (mem_rsp_valid) next_state = WAIT_WBU_READY;
			WAIT_WBU_READY: if (wbu_ready) next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (exu_valid && exu_ready) req_q <= exu_req;
		if (state == WAIT_RSP_READ && mem_rsp_valid) load_q <= load_value;
	end

	lane_align u_lane_align (
		.addr_low   (req_q.addr[1:0]),
		.load_op    (req_q.load_op),
		.store_op   (req_q.store_op),
		.store_data (req_q.store_data),
		.rdata      (mem_rsp.rdata),
		.wdata      (st_wdata),
		.be         (st_be),
		.load_value (load_value)
	);

	assign mem_req.addr = req_q.addr[31:2];
	assign mem_req.we = (state == WAIT_REQ_WRITE);
	assign mem_req.be = st_be;
	assign mem_req.wdata = st_wdata;

	always_comb begin
		lsu_commit.pc = req_q.pc;
		lsu_commit.branch_target = req_q.branch_target;
		lsu_commit.wdata = (req_q.load_op != LD_NONE) ? load_q : req_q.result;
		lsu_commit.rd = req_q.rd;
		lsu_commit.rd_we = 1'b0; // decided in wbu
		lsu_commit.is_branch = req_q.is_branch;
		lsu_commit.ecall = req_q.ecall;
		lsu_commit.mret = req_q.mret;
	end

	a_req_stable: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

	a_word_aligned: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid && (req_q.load_op == LD_LW || req_q.store_op == ST_SW)
		|-> req_q.addr[1:0] == 2'b00);

	a_half_aligned: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid && (req_q.load_op inside {LD_LH, LD_LHU} || req_q.store_op == ST_SH)
		|-> req_q.addr[0] == 1'b0);

endmodule

// File: hw/data_sram.sv
`timescale 1ns/1ps
`include "core_config.svh"

module data_sram import mem_bus_pkg::*; (
	input logic clk,
	input logic rst,

	input logic req_valid,
	output logic req_ready,
	input mem_req_t req,

	output logic rsp_valid,
	input logic rsp_ready,
	output mem_rsp_t rsp
);

	localparam int AW = $clog2(`MEM_WORDS);
	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

	logic [31:0] mem [`MEM_WORDS];
	logic [AW-1:0] idx;
	logic busy; // accepted and response not yet taken
	logic [CNT_W-1:0] cnt;
	logic [31:0] rdata_q;
	logic accept;

	assign idx = req.addr[AW-1:0]; // wraps at depth
	assign req_ready = !busy;
	assign accept = req_valid && req_ready;
	assign rsp.rdata = rdata_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			rsp_valid <= 1'b0;
			cnt <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			cnt <= CNT_W'(`MEM_LATENCY - 1);
			rsp_valid <= (`MEM_LATENCY == 1);
		end else if (busy && !rsp_valid) begin
			cnt <= cnt - 1'b1;
			if (cnt == CNT_W'(1)) rsp_valid <= 1'b1;
		end else if (rsp_valid && rsp_ready) begin
			rsp_valid <= 1'b0;
			busy <= 1'b0;
		end
	end

	// array and read word
	always_ff @(posedge clk) begin
		if (accept) begin
			rdata_q <= mem[idx]; // old contents on a write
			if (req.we) begin
				for (int i = 0; i < 4; i++) begin
					if (req.be[i]) mem[idx][8 * i +: 8] <= req.wdata[8 * i +: 8];
				end
			end
		end
	end

	a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// File: hw/wbu.sv
`timescale 1ns/1ps

module wbu import core_types_pkg::*; (
	input logic clk,
	input logic rst,

	input logic in_valid,
	output logic in_ready,
	input commit_t in_commit,

	output logic retire_valid,
	input logic retire_ready,
	output commit_t retire
);

	logic slot_valid;
	commit_t slot;
	logic rd_nz;

	assign rd_nz = (in_commit.rd != '0);
	assign in_ready = !slot_valid || retire_ready; // empty or draining now
	assign retire_valid = slot_valid;
	assign retire = slot;

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			slot_valid <= 1'b1;
		end else if (retire_ready) begin
			slot_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			slot <= in_commit;
			slot.rd_we <= rd_nz;
			slot.wdata <= rd_nz ? in_commit.wdata : '0; // x0 reads as zero
		end
	end

	a_retire_hold: assert property (@(posedge clk) disable iff (rst)
		retire_valid && !retire_ready |=> retire_valid && $stable(retire));

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import core_types_pkg::*, mem_bus_pkg::*; (
	input logic clk,
	input logic rst,

	input logic exu_valid,
	output logic exu_ready,
	input exu_req_t exu_req,

	output logic retire_valid,
	input logic retire_ready,
	output commit_t retire
);

	logic mem_req_valid;
	logic mem_req_ready;
	mem_req_t mem_req;
	logic mem_rsp_valid;
	logic mem_rsp_ready;
	mem_rsp_t mem_rsp;
	logic lsu_valid;
	logic wbu_ready;
	commit_t lsu_commit;

	lsu u_lsu (
		.clk           (clk),
		.rst           (rst),
		.exu_valid     (exu_valid),
		.exu_ready     (exu_ready),
		.exu_req       (exu_req),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_req       (mem_req),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_ready (mem_rsp_ready),
		.mem_rsp       (mem_rsp),
		.lsu_valid     (lsu_valid),
		.wbu_ready     (wbu_ready),
		.lsu_commit    (lsu_commit)
	);

	data_sram u_data_sram (
		.clk       (clk),
		.rst       (rst),
		.req_valid (mem_req_valid),
		.req_ready (mem_req_ready),
		.req       (mem_req),
		.rsp_valid (mem_rsp_valid),
		.rsp_ready (mem_rsp_ready),
		.rsp       (mem_rsp)
	);

	wbu u_wbu (
		.clk          (clk),
		.rst          (rst),
		.in_valid     (lsu_valid),
		.in_ready     (wbu_ready),
		.in_commit    (lsu_commit),
		.retire_valid (retire_valid),
		.retire_ready (retire_ready),
		.retire       (retire)
	);

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD = 40.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

endmodule

// File: test/tb_mem_stage.sv
`timescale 1ns/1ps
`include "core_config.svh"

module tb_mem_stage import core_types_pkg::*; ();

	localparam logic [31:0] SEED = 32'd69853;
	localparam int WAIT_LIMIT = 200; // cycles per wait
	localparam int BYTE_AW = $clog2(`MEM_WORDS) + 2;
	localparam logic [31:0] REGION_BASE = 32'h40; // 64 byte window where bits above BYTE_AW alias
	localparam int RANDOM_OPS = 300;

	logic clk;
	logic rst;
	logic exu_valid;
	logic exu_ready;
	exu_req_t exu_req;
	logic retire_valid;
	logic retire_ready;
	commit_t retire;

	logic [31:0] stim_lfsr = SEED;
	logic [31:0] stall_lfsr = SEED;
	logic stall_en;
	logic [7:0] shadow [64]; // byte image of the window
	commit_t exp_q [$];
	int value_errors = 0;
	int other_errors = 0;
	int issued = 0;
	int retired = 0;
	bit timed_out = 1'b0;

	tb_clock clock_gen (.clk(clk));

	mem_stage DUT (
		.clk          (clk),
		.rst          (rst),
		.exu_valid    (exu_valid),
		.exu_ready    (exu_ready),
		.exu_req      (exu_req),
		.retire_valid (retire_valid),
		.retire_ready (retire_ready),
		.retire       (retire)
	);

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	function automatic exu_req_t random_req(input load_op_e ld, input store_op_e st,
			input logic [5:0] off);
		exu_req_t r;
		logic [31:0] flags;
		r.pc = take_bits(32);
		r.branch_target = take_bits(32);
		r.addr = (take_bits(32) << BYTE_AW) | REGION_BASE | {26'b0, off};
		r.result = take_bits(32);
		r.store_data = take_bits(32);
		r.rd = reg_idx_t'(take_bits(5));
		r.load_op = ld;
		r.store_op = st;
		flags = take_bits(3);
		r.is_branch = flags[0];
		r.ecall = flags[1];
		r.mret = flags[2];
		return r;
	endfunction

	// load with a guaranteed nonzero destination
	function automatic exu_req_t load_at(input load_op_e ld, input logic [5:0] off);
		exu_req_t r;
		r = random_req(ld, ST_NONE, off);
		r.rd = reg_idx_t'(take_bits(4) + 1);
		return r;
	endfunction

	function automatic exu_req_t random_op();
		logic [31:0] sel;
		logic [5:0] off;
		sel = take_bits(3);
		off = 6'(take_bits(6));
		case (sel[2:0])
			3'd0, 3'd1: return random_req(LD_NONE, ST_NONE, off);
			3'd2: return random_req(LD_NONE, ST_SB, off);
			3'd3: return random_req(LD_NONE, ST_SH, {off[5:1], 1'b0});
			3'd4: return random_req(LD_NONE, ST_SW, {off[5:2], 2'b00});
			3'd5: return random_req(off[0] ? LD_LB : LD_LBU, ST_NONE, off);
			3'd6: return random_req(off[2] ? LD_LH : LD_LHU, ST_NONE, {off[5:1], 1'b0});
			default: return random_req(LD_LW, ST_NONE, {off[5:2], 2'b00});
		endcase
	endfunction

	// expected commit from little endian bytes of the shadow image
	function automatic commit_t expect_commit(input exu_req_t r);
		commit_t c;
		word_t v;
		int a;
		a = int'(r.addr[5:0]);
		case (r.load_op)
			LD_LB: v = {{24{shadow[a][7]}}, shadow[a]};
			LD_LBU: v = {24'b0, shadow[a]};
			LD_LH: v = {{16{shadow[a + 1][7]}}, shadow[a + 1], shadow[a]};
			LD_LHU: v = {16'b0, shadow[a + 1], shadow[a]};
			LD_LW: v = {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
			default: v = r.result;
		endcase
		c.pc = r.pc;
		c.branch_target = r.branch_target;
		c.rd = r.rd;
		c.rd_we = (r.rd != 5'd0);
		c.wdata = c.rd_we ? v : 32'd0;
		c.is_branch = r.is_branch;
		c.ecall = r.ecall;
		c.mret = r.mret;
		return c;
	endfunction

	task automatic apply_store(input exu_req_t r);
		int a;
		a = int'(r.addr[5:0]);
		case (r.store_op)
			ST_SB: shadow[a] = r.store_data[7:0];
			ST_SH: begin
				shadow[a] = r.store_data[7:0];
				shadow[a + 1] = r.store_data[15:8];
			end
			ST_SW: begin
				for (int i = 0; i < 4; i++) shadow[a + i] = r.store_data[8 * i +: 8];
			end
			default: ;
		endcase
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			value_errors++;
			$display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_commit(input commit_t got, input commit_t exp);
		check_field("retire.pc", got.pc, exp.pc);
		check_field("retire.branch_target", got.branch_target, exp.branch_target);
		check_field("retire.wdata", got.wdata, exp.wdata);
		check_field("retire.rd", {27'b0, got.rd}, {27'b0, exp.rd});
		check_field("retire.rd_we", {31'b0, got.rd_we}, {31'b0, exp.rd_we});
		check_field("retire.is_branch", {31'b0, got.is_branch}, {31'b0, exp.is_branch});
		check_field("retire.ecall", {31'b0, got.ecall}, {31'b0, exp.ecall});
		check_field("retire.mret", {31'b0, got.mret}, {31'b0, exp.mret});
	endtask

	// called on a falling edge, returns on a falling edge
	task automatic issue(input exu_req_t r);
		int n;
		if (timed_out) return;
		exu_valid = 1'b1;
		exu_req = r;
		n = 0;
		while (!exu_ready && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!exu_ready) begin
			other_errors++;
			timed_out = 1'b1;
			$display("timeout: exu_ready stayed low for %0d cycles", n);
		end else begin
			exp_q.push_back(expect_commit(r));
			apply_store(r);
			issued++;
		end
		@(negedge clk);
		exu_valid = 1'b0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			other_errors++;
			timed_out = 1'b1;
			$display("timeout: %0d instructions never retired", exp_q.size());
		end
	endtask

	// retire_ready low about one cycle in four when enabled
	initial begin
		logic b0;
		logic b1;
		retire_ready = 1'b1;
		forever begin
			@(negedge clk);
			if (stall_en) begin
				stall_lfsr = lfsr_next(stall_lfsr);
				b0 = stall_lfsr[0];
				stall_lfsr = lfsr_next(stall_lfsr);
				b1 = stall_lfsr[0];
				retire_ready = b0 | b1;
			end else begin
				retire_ready = 1'b1;
			end
		end
	end

	// scoreboard
	always @(posedge clk) begin
		commit_t held;
		bit held_valid;
		if (rst) begin
			held_valid = 1'b0;
		end else begin
			if (held_valid) begin
				assert (retire_valid === 1'b1) else begin
					other_errors++;
					$display("retire_valid dropped at %0t ns while retire_ready was low", $time);
				end
				assert (retire === held) else begin
					value_errors++;
					$display("[ERROR] %0t ns retire got %h expected %h", $time, retire, held);
				end
			end
			if (retire_valid && retire_ready) begin
				assert (exp_q.size() != 0) else begin
					other_errors++;
					$display("an instruction retired at %0t ns that was never issued", $time);
				end
				if (exp_q.size() != 0) compare_commit(retire, exp_q.pop_front());
				retired++;
			end
			held_valid = retire_valid && !retire_ready;
			held = retire;
		end
	end

	initial begin
		exu_req_t r;
		logic [31:0] gap;
		rst = 1'b1;
		exu_valid = 1'b0;
		exu_req = '0;
		stall_en = 1'b0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		check_field("exu_ready", {31'b0, exu_ready}, 32'd1);
		check_field("retire_valid", {31'b0, retire_valid}, 32'd0);

		repeat (4) issue(random_req(LD_NONE, ST_NONE, 6'd0));

		// fill the window so every later load reads known bytes
		for (int w = 0; w < 16; w++) issue(random_req(LD_NONE, ST_SW, 6'(w * 4)));
		r = random_req(LD_NONE, ST_SW, 6'h10);
		issue(r);
		r.store_op = ST_NONE;
		r.load_op = LD_LW;
		r.rd = 5'd7;
		issue(r);

		r = random_req(LD_NONE, ST_SB, 6'h29);
		r.store_data[7:0] = 8'h9c; // negative byte
		issue(r);
		r = random_req(LD_NONE, ST_SH, 6'h2e);
		r.store_data[15:0] = 16'h8a31;
		issue(r);
		for (int k = 0; k < 4; k++) begin
			issue(load_at(LD_LB, 6'(6'h28 + k)));
			issue(load_at(LD_LBU, 6'(6'h28 + k)));
		end
		issue(load_at(LD_LH, 6'h2c));
		issue(load_at(LD_LHU, 6'h2c));
		issue(load_at(LD_LH, 6'h2e));
		issue(load_at(LD_LHU, 6'h2e));
		issue(load_at(LD_LW, 6'h28));
		issue(load_at(LD_LW, 6'h2c));

		r = random_req(LD_NONE, ST_NONE, 6'd0);
		r.rd = 5'd0;
		issue(r);
		r = load_at(LD_LW, 6'h10);
		r.rd = 5'd0;
		issue(r);
		wait_drained();

		@(posedge clk);
		stall_en = 1'b1;
		@(negedge clk);
		for (int i = 0; i < RANDOM_OPS && !timed_out; i++) begin
			gap = take_bits(2);
			repeat (gap) @(negedge clk);
			issue(random_op());
		end
		wait_drained();

		// pipeline stays empty once everything has retired
		repeat (4) @(negedge clk);
		check_field("retire_valid", {31'b0, retire_valid}, 32'd0);
		check_field("exu_ready", {31'b0, exu_ready}, 32'd1);

		$display("errors: %0d value, %0d other; %0d issued, %0d retired",
			value_errors, other_errors, issued, retired);
		if (value_errors == 0 && other_errors == 0 && !timed_out && issued == retired) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hw
hw/core_types_pkg.sv
hw/mem_bus_pkg.sv
hw/lane_align.sv
hw/lsu.sv
hw/data_sram.sv
hw/wbu.sv
hw/mem_stage.sv
test/tb_clock.sv
test/tb_mem_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_stage -Mdir "$build_dir" -o tb_mem_stage_sim \
	-f filelist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/tb_mem_stage_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" "$log"; then
	exit 1
fi
exit 0
